/* all.f */
+incdir+common
common/branch_pkg.sv
common/btb_pkg.sv
common/btb_update_if.sv
btb/btb_ctrl.sv
logic/branch_cmp.sv
logic/flow_ctrl.sv
logic/ctrl_top.sv
verif/ctrl_tb.sv

/* btb/btb_ctrl.sv */
// ========================================
// 16 entry direct mapped BTB, 2-bit counters
// fetch and resolve ports read the table
// writes land on the edge, visible after
// mispredict is combinational at pc_instr_i
// ========================================
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_params.svh"

module btb_ctrl (
	input  logic              clk,
	input  logic              rst_n_i,
	input  branch_pkg::addr_t pc_pred_i,
	input  branch_pkg::addr_t pc_instr_i,
	btb_update_if.sink        upd,
	output logic              pred_taken_o,
	output branch_pkg::addr_t pred_target_o,
	output logic              mispredict_o
);

	logic [`CTRL_BTB_ENTRIES-1:0] valid_q;
	btb_pkg::btb_tag_t tag_q [`CTRL_BTB_ENTRIES];
	branch_pkg::addr_t tgt_q [`CTRL_BTB_ENTRIES];
	btb_pkg::btb_cnt_t cnt_q [`CTRL_BTB_ENTRIES];

	btb_pkg::btb_idx_t f_idx, r_idx, w_idx;
	btb_pkg::btb_tag_t f_tag, r_tag, w_tag;
	logic              f_hit, r_hit, w_hit;
	logic              r_pred_taken;
	btb_pkg::btb_cnt_t w_cnt;
	btb_pkg::btb_cnt_t w_cnt_next;

	// split addresses into index and tag
	assign f_idx = pc_pred_i[`CTRL_BTB_IDX_W+1:2];
	assign f_tag = pc_pred_i[`CTRL_XLEN-1:`CTRL_BTB_IDX_W+2];
	assign r_idx = pc_instr_i[`CTRL_BTB_IDX_W+1:2];
	assign r_tag = pc_instr_i[`CTRL_XLEN-1:`CTRL_BTB_IDX_W+2];
	assign w_idx = upd.pc[`CTRL_BTB_IDX_W+1:2];
	assign w_tag = upd.pc[`CTRL_XLEN-1:`CTRL_BTB_IDX_W+2];

	// fetch port
	assign f_hit         = valid_q[f_idx] && (tag_q[f_idx] == f_tag);
	assign pred_taken_o  = f_hit && cnt_q[f_idx][1];
	assign pred_target_o = tgt_q[f_idx];

	// resolve port, what fetch predicted for the branch now in execute
	assign r_hit        = valid_q[r_idx] && (tag_q[r_idx] == r_tag);
	assign r_pred_taken = r_hit && cnt_q[r_idx][1];

	always_comb begin
		if (upd.valid) begin
			mispredict_o = (r_pred_taken != upd.taken) ||
				(r_pred_taken && upd.taken && (tgt_q[r_idx] != upd.target));
		end else begin
			mispredict_o = r_pred_taken; // unresolved slot was fetched as taken
		end
	end

	// write port
	assign w_hit = valid_q[w_idx] && (tag_q[w_idx] == w_tag);
	assign w_cnt = cnt_q[w_idx];

	always_comb begin
		if (upd.taken) begin
			w_cnt_next = (w_cnt == 2'd3) ? w_cnt : w_cnt + 2'd1;
		end else begin
			w_cnt_next = (w_cnt == 2'd0) ? w_cnt : w_cnt - 2'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (upd.valid && !w_hit && upd.taken) begin
			valid_q[w_idx] <= 1'b1; // allocate
		end
	end

	always_ff @(posedge clk) begin
		if (upd.valid) begin
			if (w_hit) begin
				cnt_q[w_idx] <= w_cnt_next;
				if (upd.taken) begin
					tgt_q[w_idx] <= upd.target;
				end
			end else if (upd.taken) begin
				tag_q[w_idx] <= w_tag;
				tgt_q[w_idx] <= upd.target;
				cnt_q[w_idx] <= 2'd2; // weakly taken
			end
		end
	end

	// a predicted redirect must land on an instruction boundary
	a_pred_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		pred_taken_o |-> (pred_target_o[1:0] == 2'b00))
		else $error("btb predicted unaligned target %h", pred_target_o);

	a_cold_after_reset: assert property (@(posedge clk)
		$rose(rst_n_i) |-> (valid_q == '0))
		else $error("btb entry valid right after reset");

endmodule

`default_nettype wire

/* common/branch_pkg.sv */
// ========================================
// address, operand and control types of
// the branch resolver and flow control
// hold codes feed the pipeline registers
// ========================================
`default_nettype none
`include "ctrl_params.svh"

package branch_pkg;

	typedef logic [`CTRL_XLEN-1:0] addr_t; // instruction address
	typedef logic [`CTRL_XLEN-1:0] data_t; // register operand

	// decoded branch kind from the execute stage
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6,
		BR_JMP  = 3'd7  // jal / jalr, always taken
	} br_op_e;

	// which pipeline registers hold
	typedef enum logic [1:0] {
		HOLD_NONE = 2'd0,
		HOLD_IF   = 2'd1, // freeze fetch and decode
		HOLD_EX   = 2'd2  // freeze up to execute
	} hold_code_e;

endpackage

`default_nettype wire

/* common/btb_pkg.sv */
// ========================================
// BTB field types, direct mapped
// tag covers every pc bit above the index
// ========================================
`default_nettype none
`include "ctrl_params.svh"

package btb_pkg;

	// pc[5:2]
	typedef logic [`CTRL_BTB_IDX_W-1:0] btb_idx_t;

	// pc[31:6]
	typedef logic [`CTRL_XLEN-`CTRL_BTB_IDX_W-3:0] btb_tag_t;

	// 0,1 predict not taken; 2,3 predict taken
	typedef logic [1:0] btb_cnt_t;

endpackage

`default_nettype wire

/* common/btb_update_if.sv */
// ========================================
// one resolved branch per cycle, no
// handshake: the BTB takes it on every
// rising edge where valid is high
// ========================================
`timescale 1ns/1ps
`default_nettype none

interface btb_update_if;

	logic              valid;  // resolved with fresh operands
	branch_pkg::addr_t pc;     // address of the branch
	logic              taken;  // actual outcome
	branch_pkg::addr_t target; // resolved target

	modport src (
		output valid,
		output pc,
		output taken,
		output target
	);

	modport sink (
		input valid,
		input pc,
		input taken,
		input target
	);

endinterface

`default_nettype wire

/* common/ctrl_params.svh */
// ========================================
// fixed RV32 widths and the BTB geometry
// CTRL_BTB_ENTRIES must be 2**CTRL_BTB_IDX_W
// index sits right above the byte offset
// ========================================
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// data and address width
`define CTRL_XLEN 32

// pc bits [IDX_W+1:2] select the entry
`define CTRL_BTB_IDX_W 4
`define CTRL_BTB_ENTRIES 16

`define CTRL_PC_STEP 4 // bytes per instruction

// vectors in verif/ctrl_tests.txt
`define CTRL_TEST_COUNT 32

`endif

/* logic/branch_cmp.sv */
// ========================================
// execute stage branch condition and target
// load_bypass_i marks stale operands: no
// outcome and no BTB update that cycle
// ========================================
`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
	input  branch_pkg::br_op_e op_i,
	input  branch_pkg::data_t  rs1_i,
	input  branch_pkg::data_t  rs2_i,
	input  branch_pkg::addr_t  num1_i,
	input  branch_pkg::addr_t  num2_i,
	input  branch_pkg::addr_t  pc_i,
	input  logic               load_bypass_i,
	output logic               res_taken_o,
	output branch_pkg::addr_t  res_target_o,
	btb_update_if.src          upd
);

	logic rs_eq;
	logic rs_lt;  // signed
	logic rs_ltu; // unsigned
	logic cond;

	assign rs_eq  = (rs1_i == rs2_i);
	assign rs_lt  = ($signed(rs1_i) < $signed(rs2_i));
	assign rs_ltu = (rs1_i < rs2_i);

	always_comb begin
		case (op_i)
			branch_pkg::BR_BEQ:  cond = rs_eq;
			branch_pkg::BR_BNE:  cond = !rs_eq;
			branch_pkg::BR_BLT:  cond = rs_lt;
			branch_pkg::BR_BGE:  cond = !rs_lt;
			branch_pkg::BR_BLTU: cond = rs_ltu;
			branch_pkg::BR_BGEU: cond = !rs_ltu;
			branch_pkg::BR_JMP:  cond = 1'b1;
			default:             cond = 1'b0;
		endcase
	end

	assign res_taken_o  = cond && !load_bypass_i;
	assign res_target_o = num1_i + num2_i; // base plus offset for both branch and jump

	assign upd.valid  = (op_i != branch_pkg::BR_NONE) && !load_bypass_i;
	assign upd.pc     = pc_i;
	assign upd.taken  = res_taken_o;
	assign upd.target = res_target_o;

endmodule

`default_nettype wire

/* logic/ctrl_top.sv */
// ========================================
// branch and hazard control of the pipe
// fetch, decode and irq logic sit outside
// ========================================
`timescale 1ns/1ps
`default_nettype none

module ctrl_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_load_i,
	input  logic                   stall_store_i,
	input  logic                   irq_jmp_i,
	input  branch_pkg::addr_t      irq_jmp_to_i,
	input  branch_pkg::addr_t      jmp_num1_i,
	input  branch_pkg::addr_t      jmp_num2_i,
	input  branch_pkg::addr_t      pc_pred_i,
	input  branch_pkg::addr_t      pc_instr_i,
	input  branch_pkg::data_t      data_rs1_i,
	input  branch_pkg::data_t      data_rs2_i,
	input  branch_pkg::br_op_e     jmp_flag_i,
	input  logic                   load_bypass_i,
	output logic                   jmp_en_o,
	output branch_pkg::addr_t      jmp_to_o,
	output logic                   instr_mask_o,
	output branch_pkg::hold_code_e hold_code_o
);

	btb_update_if upd_if ();

	logic              res_taken;
	branch_pkg::addr_t res_target;
	logic              pred_taken;
	branch_pkg::addr_t pred_target;
	logic              mispredict;

	branch_cmp u_cmp (
		.op_i          (jmp_flag_i),
		.rs1_i         (data_rs1_i),
		.rs2_i         (data_rs2_i),
		.num1_i        (jmp_num1_i),
		.num2_i        (jmp_num2_i),
		.pc_i          (pc_instr_i),
		.load_bypass_i (load_bypass_i),
		.res_taken_o   (res_taken),
		.res_target_o  (res_target),
		.upd           (upd_if.src)
	);

	btb_ctrl u_btb (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.pc_pred_i     (pc_pred_i),
		.pc_instr_i    (pc_instr_i),
		.upd           (upd_if.sink),
		.pred_taken_o  (pred_taken),
		.pred_target_o (pred_target),
		.mispredict_o  (mispredict)
	);

	flow_ctrl u_flow (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.irq_jmp_i     (irq_jmp_i),
		.irq_jmp_to_i  (irq_jmp_to_i),
		.pc_instr_i    (pc_instr_i),
		.res_taken_i   (res_taken),
		.res_target_i  (res_target),
		.pred_taken_i  (pred_taken),
		.pred_target_i (pred_target),
		.mispredict_i  (mispredict),
		.stall_load_i  (stall_load_i),
		.stall_store_i (stall_store_i),
		.jmp_en_o      (jmp_en_o),
		.jmp_to_o      (jmp_to_o),
		.instr_mask_o  (instr_mask_o),
		.hold_code_o   (hold_code_o)
	);

endmodule

`default_nettype wire

/* logic/flow_ctrl.sv */
// ========================================
// fetch redirect priority: irq, then
// misprediction, then BTB prediction
// outputs are combinational; only the
// instruction mask is registered
// ========================================
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_params.svh"

module flow_ctrl (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   irq_jmp_i,
	input  branch_pkg::addr_t      irq_jmp_to_i,
	input  branch_pkg::addr_t      pc_instr_i,
	input  logic                   res_taken_i,
	input  branch_pkg::addr_t      res_target_i,
	input  logic                   pred_taken_i,
	input  branch_pkg::addr_t      pred_target_i,
	input  logic                   mispredict_i,
	input  logic                   stall_load_i,
	input  logic                   stall_store_i,
	output logic                   jmp_en_o,
	output branch_pkg::addr_t      jmp_to_o,
	output logic                   instr_mask_o,
	output branch_pkg::hold_code_e hold_code_o
);

	branch_pkg::addr_t fix_target; // correct path after a misprediction
	logic mask_q;

	assign fix_target = res_taken_i ? res_target_i
		: pc_instr_i + branch_pkg::addr_t'(`CTRL_PC_STEP);

	always_comb begin
		if (irq_jmp_i) begin
			jmp_en_o = 1'b1;
			jmp_to_o = irq_jmp_to_i;
		end else if (mispredict_i) begin
			jmp_en_o = 1'b1;
			jmp_to_o = fix_target;
		end else begin
			jmp_en_o = pred_taken_i;
			jmp_to_o = pred_taken_i ? pred_target_i : '0;
		end
	end

	// store stall covers more of the pipe, so it wins
	always_comb begin
		if (stall_store_i) begin
			hold_code_o = branch_pkg::HOLD_EX;
		end else if (stall_load_i) begin
			hold_code_o = branch_pkg::HOLD_IF;
		end else begin
			hold_code_o = branch_pkg::HOLD_NONE;
		end
	end

	// kill the wrong-path instruction one stage behind
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mask_q <= 1'b0;
		end else begin
			mask_q <= mispredict_i;
		end
	end

	assign instr_mask_o = mask_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the Verilator model of ctrl_tb and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module ctrl_tb \
	-Mdir obj_dir -o ctrl_sim || exit 1

out=$(./obj_dir/ctrl_sim)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && echo "PASS" || {
	echo "FAIL"
	exit 1
}

/* verif/ctrl_tb.sv */
// ========================================
// reads verif/ctrl_tests.txt from the
// project root, one vector per cycle
// R lines need a cold BTB entry at
// pc_instr and a pc_pred that misses
// ========================================
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_params.svh"

module ctrl_tb;

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 5;
	localparam int CHECK_DELAY  = 15; // outputs settled, rising edge still ahead
	localparam int WATCHDOG_NS  = (`CTRL_TEST_COUNT * 3 + RESET_CYCLES) * PERIOD;

	logic                   clk;
	logic                   rst_n_i;
	logic                   stall_load_i;
	logic                   stall_store_i;
	logic                   irq_jmp_i;
	branch_pkg::addr_t      irq_jmp_to_i;
	branch_pkg::addr_t      jmp_num1_i;
	branch_pkg::addr_t      jmp_num2_i;
	branch_pkg::addr_t      pc_pred_i;
	branch_pkg::addr_t      pc_instr_i;
	branch_pkg::data_t      data_rs1_i;
	branch_pkg::data_t      data_rs2_i;
	branch_pkg::br_op_e     jmp_flag_i;
	logic                   load_bypass_i;
	logic                   jmp_en_o;
	branch_pkg::addr_t      jmp_to_o;
	logic                   instr_mask_o;
	branch_pkg::hold_code_e hold_code_o;

	// current vector fields
	logic [31:0] v_op, v_rs1, v_rs2, v_num1, v_num2, v_pc_pred, v_pc_instr;
	logic [31:0] v_bypass, v_irq, v_irq_to, v_ld, v_st;
	logic [31:0] e_en, e_to, e_hold, e_mask;

	logic [63:0]      tok;
	logic [8*128-1:0] rest;
	logic             done;
	int fd, code;
	int tests, passed, failed, errors, test_errs, vectors;

	ctrl_top dut0 (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_load_i  (stall_load_i),
		.stall_store_i (stall_store_i),
		.irq_jmp_i     (irq_jmp_i),
		.irq_jmp_to_i  (irq_jmp_to_i),
		.jmp_num1_i    (jmp_num1_i),
		.jmp_num2_i    (jmp_num2_i),
		.pc_pred_i     (pc_pred_i),
		.pc_instr_i    (pc_instr_i),
		.data_rs1_i    (data_rs1_i),
		.data_rs2_i    (data_rs2_i),
		.jmp_flag_i    (jmp_flag_i),
		.load_bypass_i (load_bypass_i),
		.jmp_en_o      (jmp_en_o),
		.jmp_to_o      (jmp_to_o),
		.instr_mask_o  (instr_mask_o),
		.hold_code_o   (hold_code_o)
	);

	always #(PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			$display("** Error test %0d: %s expected %h got %h", tests, name, exp_v, act_v);
			errors++;
			test_errs++;
		end
	endtask

	task automatic load_inputs;
		jmp_flag_i    = branch_pkg::br_op_e'(v_op[2:0]);
		data_rs1_i    = v_rs1;
		data_rs2_i    = v_rs2;
		jmp_num1_i    = v_num1;
		jmp_num2_i    = v_num2;
		pc_pred_i     = v_pc_pred;
		pc_instr_i    = v_pc_instr;
		load_bypass_i = v_bypass[0];
		irq_jmp_i     = v_irq[0];
		irq_jmp_to_i  = v_irq_to;
		stall_load_i  = v_ld[0];
		stall_store_i = v_st[0];
	endtask

	// drive after the falling edge, sample before the rising one
	task automatic run_cycle(input logic [31:0] x_en, input logic [31:0] x_to,
		input logic [31:0] x_hold, input logic [31:0] x_mask);
		@(negedge clk);
		load_inputs();
		#(CHECK_DELAY);
		check_value("jmp_en_o", x_en, {31'd0, jmp_en_o});
		check_value("jmp_to_o", x_to, jmp_to_o);
		check_value("hold_code_o", x_hold, {30'd0, hold_code_o});
		@(posedge clk);
		#1;
		check_value("instr_mask_o", x_mask, {31'd0, instr_mask_o}); // mispredict of this cycle
	endtask

	// RV32I branch conditions
	function automatic logic taken_by_rule(input logic [31:0] op, input logic [31:0] a,
		input logic [31:0] b);
		logic r;
		case (branch_pkg::br_op_e'(op[2:0]))
			branch_pkg::BR_BEQ:  r = (a == b);
			branch_pkg::BR_BNE:  r = (a != b);
			branch_pkg::BR_BLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
			branch_pkg::BR_BGE:  r = !((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
			branch_pkg::BR_BLTU: r = (a < b);
			branch_pkg::BR_BGEU: r = !(a < b);
			branch_pkg::BR_JMP:  r = 1'b1;
			default:             r = 1'b0;
		endcase
		return r;
	endfunction

	task automatic run_random_vector;
		logic        taken;
		logic [31:0] target;
		logic [31:0] next_pc;
		v_rs1 = $urandom;
		if (($urandom % 4) == 0) begin
			v_rs2 = v_rs1; // equal operands now and then
		end else begin
			v_rs2 = $urandom;
		end
		v_num2  = $urandom & 32'h0000_0ffc;
		taken   = taken_by_rule(v_op, v_rs1, v_rs2);
		target  = v_num1 + v_num2;
		next_pc = v_pc_instr + `CTRL_PC_STEP;
		// cold entry so taken always mispredicts
		run_cycle({31'd0, taken}, taken ? target : 32'd0, e_hold, {31'd0, taken});
		v_op     = 32'd0;
		v_bypass = 32'd1;
		// an allocated entry makes this idle slot a misprediction
		run_cycle({31'd0, taken}, taken ? next_pc : 32'd0, e_hold, {31'd0, taken});
	endtask

	task automatic report_test(input string kind);
		if (test_errs == 0) begin
			passed++;
			$display("test %0d %s pc_instr %h: ok", tests, kind, v_pc_instr);
		end else begin
			failed++;
			$display("test %0d %s pc_instr %h: %0d mismatches", tests, kind, v_pc_instr,
				test_errs);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk        = 1'b0;
		rst_n_i    = 1'b0;
		v_op       = 32'd7; // a cold jump mispredicts all through reset
		v_rs1      = '0;
		v_rs2      = '0;
		v_num1     = '0;
		v_num2     = '0;
		v_pc_pred  = '0;
		v_pc_instr = '0;
		v_bypass   = '0;
		v_irq      = '0;
		v_irq_to   = '0;
		v_ld       = '0;
		v_st       = '0;
		tests      = 0;
		passed     = 0;
		failed     = 0;
		errors     = 0;
		test_errs  = 0;
		vectors    = 0;
		done       = 1'b0;
		void'($urandom(71));
		load_inputs();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);

		tests++;
		test_errs = 0;
		check_value("instr_mask_o", 32'd0, {31'd0, instr_mask_o}); // held low by reset
		v_op = '0;
		load_inputs();
		rst_n_i = 1'b1;
		run_cycle(32'd0, 32'd0, 32'd0, 32'd0); // nothing predicted, nothing masked
		report_test("reset");

		fd = $fopen("verif/ctrl_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/ctrl_tests.txt");
			errors++;
		end else begin
			while (!done) begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1) begin
					done = 1'b1;
				end else if (tok[7:0] == "#") begin
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						v_op, v_rs1, v_rs2, v_num1, v_num2, v_pc_pred, v_pc_instr,
						v_bypass, v_irq, v_irq_to, v_ld, v_st, e_en, e_to, e_hold, e_mask);
					if (code != 16) begin
						$display("malformed vector after %0d vectors", vectors);
						errors++;
						done = 1'b1;
					end else begin
						vectors++;
						tests++;
						test_errs = 0;
						if (tok[7:0] == "R") begin
							run_random_vector();
							report_test("random");
						end else if (tok[7:0] == "V") begin
							run_cycle(e_en, e_to, e_hold, e_mask);
							report_test("fixed");
						end else begin
							$display("unknown vector kind in vector %0d", vectors);
							errors++;
							failed++;
						end
					end
				end
			end
			$fclose(fd);
		end

		if (vectors != `CTRL_TEST_COUNT) begin
			$display("vector file held %0d vectors instead of %0d", vectors, `CTRL_TEST_COUNT);
			errors++;
		end

		$display("tests %0d  passed %0d  failed %0d  errors %0d", tests, passed, failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/ctrl_tests.txt */
# kind op rs1 rs2 num1 num2 pc_pred pc_instr bypass irq irq_to ld_stall st_stall
# then expected jmp_en jmp_to hold_code and instr_mask one cycle later, all hex
# cold BTB, each op taken and not taken with boundary operands
V 1 00000005 00000005 00001000 00000040 00000200 00001000 0 0 00000000 0 0 1 00001040 0 1
V 1 00000005 00000006 00001004 00000040 00000200 00001004 0 0 00000000 0 0 0 00000000 0 0
V 2 00000000 00000001 00001008 fffffff0 00000200 00001008 0 0 00000000 0 0 1 00000ff8 0 1
V 2 ffffffff ffffffff 0000100c 00000040 00000200 0000100c 0 0 00000000 0 0 0 00000000 0 0
V 3 80000000 7fffffff 00001010 00000100 00000200 00001010 0 0 00000000 0 0 1 00001110 0 1
V 3 7fffffff 80000000 00001014 00000100 00000200 00001014 0 0 00000000 0 0 0 00000000 0 0
V 4 ffffffff ffffffff 00001018 00000020 00000200 00001018 0 0 00000000 0 0 1 00001038 0 1
V 4 80000000 00000000 0000101c 00000020 00000200 0000101c 0 0 00000000 0 0 0 00000000 0 0
V 5 7fffffff 80000000 00001020 00000008 00000200 00001020 0 0 00000000 0 0 1 00001028 0 1
V 5 ffffffff 00000000 00001024 00000008 00000200 00001024 0 0 00000000 0 0 0 00000000 0 0
V 6 00000000 00000000 00001028 0000000c 00000200 00001028 0 0 00000000 0 0 1 00001034 0 1
V 6 00000000 ffffffff 0000102c 0000000c 00000200 0000102c 0 0 00000000 0 0 0 00000000 0 0
V 7 00000000 00000000 00004000 00000010 00000200 00001030 0 0 00000000 0 0 1 00004010 0 1
# training at 00002034: allocate, strengthen, predict, confirm, weaken
V 1 00000003 00000003 00002034 000001cc 00000200 00002034 0 0 00000000 0 0 1 00002200 0 1
V 1 00000003 00000003 00002034 000001cc 00000200 00002034 0 0 00000000 0 0 0 00000000 0 0
V 0 00000000 00000000 00000000 00000000 00002034 00003000 0 0 00000000 0 0 1 00002200 0 0
V 1 00000003 00000003 00002034 000001cc 00002038 00002034 0 0 00000000 0 0 0 00000000 0 0
V 1 00000003 00000004 00002034 000001cc 00000200 00002034 0 0 00000000 0 0 1 00002038 0 1
V 0 00000000 00000000 00000000 00000000 00002034 00003000 0 0 00000000 0 0 1 00002200 0 0
# interrupt over misprediction and prediction, then over prediction alone
V 2 00000001 00000002 00003004 00000100 00002034 00003004 0 1 00000080 0 0 1 00000080 0 1
V 0 00000000 00000000 00000000 00000000 00002034 00003000 0 1 00000100 0 0 1 00000100 0 0
# stale operands leave the BTB untouched
V 1 00000007 00000007 00003008 00000010 00000200 00003008 1 0 00000000 0 0 0 00000000 0 0
V 0 00000000 00000000 00000000 00000000 00003008 00003008 0 0 00000000 0 0 0 00000000 0 0
# hold code for each stall combination
V 0 00000000 00000000 00000000 00000000 00000200 00003000 0 0 00000000 0 0 0 00000000 0 0
V 0 00000000 00000000 00000000 00000000 00000200 00003000 0 0 00000000 1 0 0 00000000 1 0
V 0 00000000 00000000 00000000 00000000 00000200 00003000 0 0 00000000 0 1 0 00000000 2 0
V 0 00000000 00000000 00000000 00000000 00000200 00003000 0 0 00000000 1 1 0 00000000 2 0
# random operands, expected values computed by the testbench
R 3 00000000 00000000 00005000 00000000 00000200 00005000 0 0 00000000 0 0 0 00000000 0 0
R 6 00000000 00000000 00005004 00000000 00000200 00005004 0 0 00000000 0 0 0 00000000 0 0
R 2 00000000 00000000 00005008 00000000 00000200 00005008 0 0 00000000 0 0 0 00000000 0 0
R 5 00000000 00000000 0000500c 00000000 00000200 0000500c 0 0 00000000 0 0 0 00000000 0 0
R 4 00000000 00000000 00005010 00000000 00000200 00005010 0 0 00000000 0 0 0 00000000 0 0
